//--- Makefile
# Verilator flow for the colour segmentation pipeline
# any variable below can be overridden, e.g. make sim LOG=run.log

VERILATOR  ?= verilator
FILELIST   ?= build.f
TB_TOP     ?= color_seg_tb
RTL_TOP    ?= color_seg_top
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= No errors
VFLAGS     ?= --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := hw/color_seg_config.svh
SIM_BIN := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) --binary $(SIM_FLAGS) $(VFLAGS) -f $(FILELIST) \
		--top-module $(TB_TOP) -Mdir $(OBJ_DIR)

sim: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
+incdir+hw
hw/color_seg_pkg.sv
hw/ycbcr_capture.sv
hw/ycbcr_to_rgb.sv
hw/rgb_to_hsv.sv
hw/color_classifier.sv
hw/color_seg_top.sv
verification/tb_clock_gen.sv
verification/color_seg_tb.sv

//--- hw/color_classifier.sv
`timescale 1ns/1ps
`include "color_seg_config.svh"

module color_classifier (
	input  logic                       clk_llc,
	input  logic                       resetx,
	input  logic                       hsv_valid,
	input  color_seg_pkg::byte_t       h,
	input  color_seg_pkg::byte_t       s,
	input  color_seg_pkg::byte_t       v,
	output logic                       class_valid,
	output color_seg_pkg::class_word_t class_word
);
	import color_seg_pkg::*;

	logic        black;
	logic        chroma;   // bright and saturated
	logic        red_b;
	logic        orange_b;
	logic        yellow_b;
	logic        green_b;
	logic        blue_b;
	class_word_t word_c;

	// open window center +- HUE_WIN
	function automatic logic in_window(input byte_t hue, input byte_t center);
		return (hue > center - `HUE_WIN) && (hue < center + `HUE_WIN);
	endfunction

	assign black    = v < `V_THRESH;
	assign chroma   = !black && (s > `S_THRESH);
	assign red_b    = chroma && in_window(h, `HUE_RED);
	assign orange_b = chroma && in_window(h, `HUE_ORANGE);
	assign yellow_b = chroma && in_window(h, `HUE_YELLOW);
	assign green_b  = chroma && in_window(h, `HUE_GREEN);
	assign blue_b   = chroma && in_window(h, `HUE_BLUE);

	// ------------------------------
	// class word, msb first
	// ------------------------------
	assign word_c = {
		red_b | orange_b | yellow_b,                     // 15
		red_b | orange_b | yellow_b | black,             // 14
		red_b,                                           // 13
		orange_b,                                        // 12
		yellow_b,                                        // 11
		green_b | yellow_b,                              // 10
		green_b | yellow_b | orange_b | black,           // 9
		green_b | yellow_b | orange_b,                   // 8
		green_b,                                         // 7
		green_b,
		green_b,
		blue_b,                                          // 4
		blue_b | black,
		blue_b,
		blue_b,
		black                                            // 0
	};

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			class_valid <= 1'b0;
			class_word  <= '0;
		end
		else
		begin
			class_valid <= hsv_valid;
			if (hsv_valid)
				class_word <= word_c;  // idle hsv data never reaches the word
		end
	end

	// windows are disjoint
	assert property (@(posedge clk_llc) disable iff (!resetx)
		class_valid |-> $onehot0({class_word[13], class_word[12], class_word[11],
			class_word[7], class_word[4]}));

	// black pixels carry no colour
	assert property (@(posedge clk_llc) disable iff (!resetx)
		class_valid && class_word[0] |->
			class_word[13:11] == 3'b000 && !class_word[7] && !class_word[4]);

endmodule

//--- hw/color_seg_config.svh
`ifndef COLOR_SEG_CONFIG_SVH
`define COLOR_SEG_CONFIG_SVH

// ------------------------------
// ycbcr to rgb, 2.8 fixed point
// ------------------------------
`define COEF_Y       10'd298   // 1.164
`define COEF_R_CR    10'd409   // 1.596
`define COEF_G_CR    10'd208   // 0.813
`define COEF_G_CB    10'd100   // 0.392
`define COEF_B_CB    10'd516   // 2.017

// video range offsets
`define Y_OFFSET     10'd16
`define C_OFFSET     10'd128

// ------------------------------
// hsv scale
// ------------------------------
`define HUE_FULL     8'd240    // one turn of the hue circle
`define HUE_SECTOR   8'd40     // 60 degrees

// black / chroma limits
`define V_THRESH     8'd96
`define S_THRESH     8'd96

// hue window centers
`define HUE_RED      8'd230
`define HUE_ORANGE   8'd15
`define HUE_YELLOW   8'd40
`define HUE_GREEN    8'd90
`define HUE_BLUE     8'd144
`define HUE_WIN      8'd10     // half width, both ends open

// sampling edge of the last byte to class_valid
`define PIPE_LATENCY 7

`endif

//--- hw/color_seg_pkg.sv
package color_seg_pkg;

	// one video byte or one colour component
	typedef logic [7:0] byte_t;

	// result word read by the robot software
	typedef logic [15:0] class_word_t;

	// byte position inside a cb y0 cr y1 group
	typedef enum logic [1:0]
	{
		phase_cb,
		phase_y0,
		phase_cr,
		phase_y1
	} capture_phase_e;

	// channel holding the maximum, ties go r > g > b
	typedef enum logic [1:0]
	{
		max_r,
		max_g,
		max_b
	} max_chan_e;

endpackage

//--- hw/color_seg_top.sv
`timescale 1ns/1ps

module color_seg_top (
	input  logic                       clk_llc,
	input  logic                       resetx,
	input  color_seg_pkg::byte_t       video_byte,
	input  logic                       line_active,
	output logic                       class_valid,
	output color_seg_pkg::class_word_t class_word
);
	import color_seg_pkg::*;

	// capture -> rgb
	logic  pix_valid;
	byte_t y;
	byte_t cb;
	byte_t cr;
	// rgb -> hsv
	logic  rgb_valid;
	byte_t r;
	byte_t g;
	byte_t b;
	// hsv -> classifier
	logic  hsv_valid;
	byte_t h;
	byte_t s;
	byte_t v;

	ycbcr_capture capture_i (
		.clk_llc     (clk_llc),
		.resetx      (resetx),
		.video_byte  (video_byte),
		.line_active (line_active),
		.pix_valid   (pix_valid),
		.y           (y),
		.cb          (cb),
		.cr          (cr)
	);

	ycbcr_to_rgb to_rgb_i (
		.clk_llc   (clk_llc),
		.resetx    (resetx),
		.pix_valid (pix_valid),
		.y         (y),
		.cb        (cb),
		.cr        (cr),
		.rgb_valid (rgb_valid),
		.r         (r),
		.g         (g),
		.b         (b)
	);

	rgb_to_hsv to_hsv_i (
		.clk_llc   (clk_llc),
		.resetx    (resetx),
		.rgb_valid (rgb_valid),
		.r         (r),
		.g         (g),
		.b         (b),
		.hsv_valid (hsv_valid),
		.h         (h),
		.s         (s),
		.v         (v)
	);

	color_classifier classifier_i (
		.clk_llc     (clk_llc),
		.resetx      (resetx),
		.hsv_valid   (hsv_valid),
		.h           (h),
		.s           (s),
		.v           (v),
		.class_valid (class_valid),
		.class_word  (class_word)
	);

endmodule

//--- hw/rgb_to_hsv.sv
`timescale 1ns/1ps
`include "color_seg_config.svh"

module rgb_to_hsv (
	input  logic                 clk_llc,
	input  logic                 resetx,
	input  logic                 rgb_valid,
	input  color_seg_pkg::byte_t r,
	input  color_seg_pkg::byte_t g,
	input  color_seg_pkg::byte_t b,
	output logic                 hsv_valid,
	output color_seg_pkg::byte_t h,
	output color_seg_pkg::byte_t s,
	output color_seg_pkg::byte_t v
);
	import color_seg_pkg::*;

	// sector bases for green and blue maxima
	localparam logic signed [15:0] hue_base_g = 16'(2 * `HUE_SECTOR);
	localparam logic signed [15:0] hue_base_b = 16'(4 * `HUE_SECTOR);

	logic [2:0]         vld_sr;
	byte_t              max_c;
	byte_t              min_c;
	max_chan_e          chan_c;
	byte_t              max_q;    // stage 1
	byte_t              min_q;
	max_chan_e          chan_q;
	byte_t              r_q;
	byte_t              g_q;
	byte_t              b_q;
	logic signed [8:0]  diff_c;
	byte_t              delta_q;  // stage 2
	logic signed [8:0]  diff_q;   // signed hue difference
	byte_t              v2_q;
	max_chan_e          chan2_q;
	logic signed [15:0] hue_num;
	logic signed [15:0] hue_quo;  // -40..40
	logic signed [15:0] hue_c;
	logic [15:0]        sat_num;
	logic [15:0]        sat_c;

	// max with its channel tag, and min
	always_comb
	begin
		if (r >= g && r >= b)
		begin
			max_c  = r;
			chan_c = max_r;
		end
		else if (g >= b)
		begin
			max_c  = g;
			chan_c = max_g;
		end
		else
		begin
			max_c  = b;
			chan_c = max_b;
		end
		min_c = r;
		if (g < min_c)
			min_c = g;
		if (b < min_c)
			min_c = b;
	end

	// difference of the two channels that are not the max
	always_comb
	begin
		case (chan_q)
			max_r:   diff_c = $signed({1'b0, g_q}) - $signed({1'b0, b_q});
			max_g:   diff_c = $signed({1'b0, b_q}) - $signed({1'b0, r_q});
			max_b:   diff_c = $signed({1'b0, r_q}) - $signed({1'b0, g_q});
			default: diff_c = '0;
		endcase
	end

	// ------------------------------
	// stage 3 dividers
	// ------------------------------
	assign hue_num = diff_q * $signed({8'd0, `HUE_SECTOR});
	assign hue_quo = hue_num / $signed({8'd0, delta_q});  // truncates toward zero
	assign sat_num = delta_q * 16'd255;
	assign sat_c   = (v2_q == 8'd0) ? 16'd0 : sat_num / {8'd0, v2_q};

	always_comb
	begin
		if (delta_q == 8'd0)
			hue_c = '0;  // grey, no hue
		else
		begin
			case (chan2_q)
				max_r:   hue_c = (hue_quo < 0) ? hue_quo + $signed({8'd0, `HUE_FULL}) : hue_quo;
				max_g:   hue_c = hue_quo + hue_base_g;
				max_b:   hue_c = hue_quo + hue_base_b;
				default: hue_c = '0;
			endcase
		end
	end

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			vld_sr  <= '0;
			max_q   <= '0;
			min_q   <= '0;
			chan_q  <= max_r;
			r_q     <= '0;
			g_q     <= '0;
			b_q     <= '0;
			delta_q <= '0;
			diff_q  <= '0;
			v2_q    <= '0;
			chan2_q <= max_r;
			h       <= '0;
			s       <= '0;
			v       <= '0;
		end
		else
		begin
			vld_sr  <= {vld_sr[1:0], rgb_valid};
			max_q   <= max_c;           // stage 1
			min_q   <= min_c;
			chan_q  <= chan_c;
			r_q     <= r;
			g_q     <= g;
			b_q     <= b;
			delta_q <= max_q - min_q;   // stage 2
			diff_q  <= diff_c;
			v2_q    <= max_q;
			chan2_q <= chan_q;
			h       <= hue_c[7:0];      // stage 3
			s       <= sat_c[7:0];
			v       <= v2_q;
		end
	end

	assign hsv_valid = vld_sr[2];

	// red wrap keeps the hue on the 240 step circle
	assert property (@(posedge clk_llc) disable iff (!resetx)
		hsv_valid |-> h < `HUE_FULL);

endmodule

//--- hw/ycbcr_capture.sv
`timescale 1ns/1ps

module ycbcr_capture (
	input  logic                 clk_llc,
	input  logic                 resetx,
	input  color_seg_pkg::byte_t video_byte,
	input  logic                 line_active,
	output logic                 pix_valid,
	output color_seg_pkg::byte_t y,
	output color_seg_pkg::byte_t cb,
	output color_seg_pkg::byte_t cr
);
	import color_seg_pkg::*;

	byte_t          byte_q;    // decoder byte at the pins
	logic           active_q;  // line_active, same cycle as byte_q
	capture_phase_e phase;
	byte_t          cb_q;      // chroma of the current group
	byte_t          y0_q;

	// input register
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			byte_q   <= '0;
			active_q <= 1'b0;
		end
		else
		begin
			byte_q   <= video_byte;
			active_q <= line_active;
		end
	end

	// ------------------------------
	// phase sequencer
	// ------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
			phase <= phase_cb;
		else if (!active_q)
			phase <= phase_cb;  // blanking, restart at cb
		else
		begin
			case (phase)
				phase_cb: phase <= phase_y0;
				phase_y0: phase <= phase_cr;
				phase_cr: phase <= phase_y1;
				phase_y1: phase <= phase_cb;
			endcase
		end
	end

	// byte latches and pixel output
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			cb_q      <= '0;
			y0_q      <= '0;
			pix_valid <= 1'b0;
			y         <= '0;
			cb        <= '0;
			cr        <= '0;
		end
		else
		begin
			pix_valid <= 1'b0;  // one pulse per pixel
			if (active_q)
			begin
				case (phase)
					phase_cb: cb_q <= byte_q;
					phase_y0: y0_q <= byte_q;
					phase_cr:
					begin
						y         <= y0_q;    // first pixel
						cb        <= cb_q;
						cr        <= byte_q;
						pix_valid <= 1'b1;
					end
					phase_y1:
					begin
						y         <= byte_q;  // second pixel, chroma kept
						pix_valid <= 1'b1;
					end
				endcase
			end
		end
	end

	// pixels leave only after cr or y1, the sequencer is then past y0
	assert property (@(posedge clk_llc) disable iff (!resetx)
		!(pix_valid && phase == phase_y0));

endmodule

//--- hw/ycbcr_to_rgb.sv
`timescale 1ns/1ps
`include "color_seg_config.svh"

module ycbcr_to_rgb (
	input  logic                 clk_llc,
	input  logic                 resetx,
	input  logic                 pix_valid,
	input  color_seg_pkg::byte_t y,
	input  color_seg_pkg::byte_t cb,
	input  color_seg_pkg::byte_t cr,
	output logic                 rgb_valid,
	output color_seg_pkg::byte_t r,
	output color_seg_pkg::byte_t g,
	output color_seg_pkg::byte_t b
);
	import color_seg_pkg::*;

	logic [1:0]         vld_sr;   // one bit per stage
	logic signed [9:0]  y_off;    // y - 16
	logic signed [9:0]  cb_off;   // cb - 128
	logic signed [9:0]  cr_off;   // cr - 128
	logic signed [20:0] y_p;      // products, 2.8 scaled
	logic signed [20:0] rcr_p;
	logic signed [20:0] gcr_p;
	logic signed [20:0] gcb_p;
	logic signed [20:0] bcb_p;
	logic signed [20:0] r_sum;
	logic signed [20:0] g_sum;
	logic signed [20:0] b_sum;

	// >>> 8 and clamp to 0..255
	function automatic byte_t clamp8(input logic signed [20:0] acc);
		byte_t res;
		if (acc[20])
			res = 8'd0;         // negative
		else if (|acc[19:16])
			res = 8'd255;       // overflow past 255
		else
			res = acc[15:8];
		return res;
	endfunction

	assign y_off  = $signed({2'b00, y}) - $signed(`Y_OFFSET);
	assign cb_off = $signed({2'b00, cb}) - $signed(`C_OFFSET);
	assign cr_off = $signed({2'b00, cr}) - $signed(`C_OFFSET);

	// ------------------------------
	// stage 1, coefficient products
	// ------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			y_p   <= '0;
			rcr_p <= '0;
			gcr_p <= '0;
			gcb_p <= '0;
			bcb_p <= '0;
		end
		else
		begin
			y_p   <= y_off * $signed({1'b0, `COEF_Y});
			rcr_p <= cr_off * $signed({1'b0, `COEF_R_CR});
			gcr_p <= cr_off * $signed({1'b0, `COEF_G_CR});
			gcb_p <= cb_off * $signed({1'b0, `COEF_G_CB});
			bcb_p <= cb_off * $signed({1'b0, `COEF_B_CB});
		end
	end

	assign r_sum = y_p + rcr_p;
	assign g_sum = y_p - gcr_p - gcb_p;
	assign b_sum = y_p + bcb_p;

	// stage 2, sums, shift, clamp
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			vld_sr <= '0;
			r      <= '0;
			g      <= '0;
			b      <= '0;
		end
		else
		begin
			vld_sr <= {vld_sr[0], pix_valid};
			r      <= clamp8(r_sum);
			g      <= clamp8(g_sum);
			b      <= clamp8(b_sum);
		end
	end

	assign rgb_valid = vld_sr[1];

endmodule

//--- verification/color_seg_tb.sv
`timescale 1ns/1ps
`include "color_seg_config.svh"

module color_seg_tb;
	import color_seg_pkg::*;

	localparam int reset_cycles  = 8;
	localparam int random_groups = 200;

	logic        clk_llc;
	logic        resetx;
	byte_t       video_byte;
	logic        line_active;
	logic        class_valid;
	class_word_t class_word;

	// stimulus table with one entry per cb y0 cr y1 group
	string tbl_name[$];
	int    tbl_len[$];    // bytes driven where 4 is a full group
	byte_t tbl_y0[$];
	byte_t tbl_y1[$];
	byte_t tbl_cb[$];
	byte_t tbl_cr[$];
	int    tbl_idle[$];   // blanking cycles after the group

	// pixels in flight with the oldest first
	string       exp_name_q[$];
	class_word_t exp_word_q[$];
	int          exp_cycle_q[$];  // cycle count when class_valid is due

	int          cycle       = 0;
	int          cycle_limit = 0;
	int          checks      = 0;
	int          errors      = 0;
	logic        seen_pulse  = 1'b0;
	logic [31:0] lfsr_state  = 32'he7f58393;
	string       pop_name;
	class_word_t pop_word;
	int          pop_cycle;

	tb_clock_gen clock_gen_i (
		.clk_llc (clk_llc),
		.resetx  (resetx)
	);

	color_seg_top color_seg_top_i (
		.clk_llc     (clk_llc),
		.resetx      (resetx),
		.video_byte  (video_byte),
		.line_active (line_active),
		.class_valid (class_valid),
		.class_word  (class_word)
	);

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic int clamp_channel(input int val);
		if (val < 0)
			return 0;
		if (val > 255)
			return 255;
		return val;
	endfunction

	function automatic logic hue_in_window(input int hue, input int center);
		int win;
		win = int'(`HUE_WIN);
		return (hue > center - win) && (hue < center + win);  // open both ends
	endfunction

	function automatic class_word_t expected_class(input byte_t yv, input byte_t cbv,
		input byte_t crv);
		int          luma;    // coef_y * (y - 16)
		int          cbs;
		int          crs;
		int          rc;
		int          gc;
		int          bc;
		int          vmax;
		int          vmin;
		int          delta;
		int          sat;
		int          hue;
		int          sector;
		logic        blk;
		logic        chr;
		logic        red;
		logic        ora;
		logic        yel;
		logic        grn;
		logic        blu;
		class_word_t word;
		sector = int'(`HUE_SECTOR);
		luma   = int'(`COEF_Y) * (int'(yv) - int'(`Y_OFFSET));
		cbs    = int'(cbv) - int'(`C_OFFSET);
		crs    = int'(crv) - int'(`C_OFFSET);
		rc     = clamp_channel((luma + int'(`COEF_R_CR) * crs) >>> 8);
		gc     = clamp_channel((luma - int'(`COEF_G_CR) * crs - int'(`COEF_G_CB) * cbs) >>> 8);
		bc     = clamp_channel((luma + int'(`COEF_B_CB) * cbs) >>> 8);
		vmax   = (rc > gc) ? rc : gc;
		vmax   = (bc > vmax) ? bc : vmax;
		vmin   = (rc < gc) ? rc : gc;
		vmin   = (bc < vmin) ? bc : vmin;
		delta  = vmax - vmin;
		sat    = (vmax == 0) ? 0 : delta * 255 / vmax;
		// hue sectors with ties going r over g over b
		if (delta == 0)
			hue = 0;
		else if (rc >= gc && rc >= bc)
			hue = (sector * (gc - bc) / delta + int'(`HUE_FULL)) % int'(`HUE_FULL);
		else if (gc >= bc)
			hue = sector * (bc - rc) / delta + 2 * sector;
		else
			hue = sector * (rc - gc) / delta + 4 * sector;
		blk = vmax < int'(`V_THRESH);
		chr = !blk && (sat > int'(`S_THRESH));
		red = chr && hue_in_window(hue, int'(`HUE_RED));
		ora = chr && hue_in_window(hue, int'(`HUE_ORANGE));
		yel = chr && hue_in_window(hue, int'(`HUE_YELLOW));
		grn = chr && hue_in_window(hue, int'(`HUE_GREEN));
		blu = chr && hue_in_window(hue, int'(`HUE_BLUE));
		word[15] = red | ora | yel;
		word[14] = red | ora | yel | blk;
		word[13] = red;
		word[12] = ora;
		word[11] = yel;
		word[10] = grn | yel;
		word[9]  = grn | yel | ora | blk;
		word[8]  = grn | yel | ora;
		word[7]  = grn;
		word[6]  = grn;
		word[5]  = grn;
		word[4]  = blu;
		word[3]  = blu | blk;
		word[2]  = blu;
		word[1]  = blu;
		word[0]  = blk;
		return word;
	endfunction

	// x^32 + x^22 + x^2 + x + 1 stepped once per bit
	function automatic logic lfsr_bit();
		logic fb;
		fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic byte_t random_bits(input int nbits);
		byte_t val;
		val = '0;
		for (int k = 0; k < nbits; k++)
			val = {val[6:0], lfsr_bit()};
		return val;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks = checks + 1;
		if (expected !== actual)
		begin
			errors = errors + 1;
			$display("mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		end
	endtask

	// ------------------------------
	// stimulus table
	// ------------------------------
	task automatic add_group(input string name, input int len, input byte_t y0,
		input byte_t y1, input byte_t cb, input byte_t cr, input int idle);
		tbl_name.push_back(name);
		tbl_len.push_back(len);
		tbl_y0.push_back(y0);
		tbl_y1.push_back(y1);
		tbl_cb.push_back(cb);
		tbl_cr.push_back(cr);
		tbl_idle.push_back(idle);
	endtask

	task automatic build_table();
		byte_t ry0;
		byte_t ry1;
		byte_t rcb;
		byte_t rcr;
		int    ridle;
		//        name             len  y0   y1   cb   cr   idle
		add_group("black",          4,  16,  40, 128, 128, 2);
		add_group("dark_red",       4,  40,  50, 120, 160, 1);
		add_group("grey",           4, 180, 235, 128, 128, 2);  // zero words
		add_group("pale_red",       4, 164, 150, 122, 146, 1);  // s under threshold
		add_group("red",            4,  72,  80, 120, 212, 1);
		add_group("orange",         4, 114, 120,  72, 194, 1);
		add_group("yellow",         4, 168, 160,  40, 142, 1);
		add_group("green",          4, 122, 110,  92,  51, 1);
		add_group("blue",           4,  76,  70, 192,  84, 1);
		add_group("green_edge",     4, 122, 122, 115,  51, 1);  // hue 100 just past green
		add_group("red_edge",       4,  72,  72, 146, 212, 2);  // hue 220 just below red
		add_group("part_cb_y0",     2, 100,   0,  90, 200, 3);  // no pixel
		add_group("after_part",     4, 114, 114,  72, 194, 1);
		add_group("part_cr",        3,  72,   0, 120, 212, 2);  // first pixel only
		add_group("after_part_cr",  4, 122, 122,  92,  51, 1);
		add_group("stream_red",     4,  72,  72, 120, 212, 0);
		add_group("stream_green",   4, 122, 122,  92,  51, 0);
		add_group("stream_blue",    4,  76,  76, 192,  84, 0);
		add_group("stream_yellow",  4, 168, 168,  40, 142, 0);
		add_group("stream_black",   4,  16,  16, 128, 128, 3);
		for (int k = 0; k < random_groups; k++)
		begin
			ry0   = random_bits(8);
			ry1   = random_bits(8);
			rcb   = random_bits(8);
			rcr   = random_bits(8);
			ridle = int'(random_bits(2));  // 0..3 gap
			add_group($sformatf("random_%0d", k), 4, ry0, ry1, rcb, rcr, ridle);
		end
	endtask

	function automatic int run_cycles();
		int total;
		total = reset_cycles + 4;
		foreach (tbl_idle[i])
			total = total + 4 + tbl_idle[i];
		return total + 2 * `PIPE_LATENCY + 100;
	endfunction

	// byte sampled on the next rising edge and word due PIPE_LATENCY later
	task automatic queue_pixel(input string name, input byte_t yv, input byte_t cbv,
		input byte_t crv);
		exp_name_q.push_back(name);
		exp_word_q.push_back(expected_class(yv, cbv, crv));
		exp_cycle_q.push_back(cycle + 1 + `PIPE_LATENCY);
	endtask

	task automatic apply_group(input int idx);
		byte_t seq [4];
		seq[0] = tbl_cb[idx];
		seq[1] = tbl_y0[idx];
		seq[2] = tbl_cr[idx];
		seq[3] = tbl_y1[idx];
		for (int k = 0; k < tbl_len[idx]; k++)
		begin
			@(negedge clk_llc);
			video_byte  = seq[k];
			line_active = 1'b1;
			if (k == 2)
				queue_pixel(tbl_name[idx], tbl_y0[idx], tbl_cb[idx], tbl_cr[idx]);
			else if (k == 3)
				queue_pixel(tbl_name[idx], tbl_y1[idx], tbl_cb[idx], tbl_cr[idx]);
		end
		for (int k = 0; k < tbl_idle[idx]; k++)
		begin
			@(negedge clk_llc);
			video_byte  = '0;
			line_active = 1'b0;  // blanking
		end
	endtask

	// ------------------------------
	// cycle count and watchdog
	// ------------------------------
	always @(posedge clk_llc)
	begin
		cycle = cycle + 1;
		if (cycle_limit > 0 && cycle > cycle_limit)
		begin
			$display("timeout after %0d cycles, %0d pixels never classified",
				cycle, exp_word_q.size());
			$display("Errors found");
			$finish;
		end
	end

	// output monitor sampled away from the active edge
	always @(negedge clk_llc)
	begin
		if (class_valid)
		begin
			if (exp_word_q.size() == 0)
			begin
				errors = errors + 1;
				$display("class_valid pulsed at cycle %0d with no pixel outstanding", cycle);
			end
			else
			begin
				pop_name  = exp_name_q.pop_front();
				pop_word  = exp_word_q.pop_front();
				pop_cycle = exp_cycle_q.pop_front();
				check_value({pop_name, " word"}, pop_word, class_word);
				check_value({pop_name, " latency"}, pop_cycle, cycle);
				seen_pulse = 1'b1;
			end
		end
		else if (!seen_pulse)
			check_value("reset word", 32'h0, class_word);  // still cleared
	end

	initial
	begin
		video_byte  = '0;
		line_active = 1'b0;
		build_table();
		cycle_limit = run_cycles();
		wait (resetx == 1'b1);
		repeat (2) @(negedge clk_llc);
		for (int i = 0; i < tbl_name.size(); i++)
			apply_group(i);
		@(negedge clk_llc);
		video_byte  = '0;
		line_active = 1'b0;  // last group may have no gap
		while (exp_word_q.size() != 0)
			@(negedge clk_llc);
		repeat (`PIPE_LATENCY + 2) @(negedge clk_llc);  // catch stray pulses
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk_llc,
	output logic resetx
);
	localparam int half_period  = 5;  // 10 ns clock
	localparam int reset_cycles = 8;

	initial
	begin
		clk_llc = 1'b0;
		forever #half_period clk_llc = ~clk_llc;
	end

	// release away from the sampling edge
	initial
	begin
		resetx = 1'b0;
		repeat (reset_cycles) @(posedge clk_llc);
		@(negedge clk_llc);
		resetx = 1'b1;
	end

endmodule
